/* common/loader_macros.svh */
// Build constants for the program loader. The bit time assumes a 27 MHz clock at 115200 baud.
// The memory depth must be a power of two.
`ifndef LOADER_MACROS_SVH
`define LOADER_MACROS_SVH

// ####################
// Serial timing
// ####################

// Clock cycles per serial bit.
`define LOADER_CLKS_PER_BIT 234

// ####################
// Instruction memory
// ####################

// Words in the instruction memory.
`define LOADER_MEM_DEPTH 256

// addi x0, x0, 1.
`define LOADER_NOP_WORD 32'h0010_0013

`endif

/* common/loaderPkg.sv */
// Shared types of the program loader.
// Address and count widths follow LOADER_MEM_DEPTH.
`default_nettype none

`include "loader_macros.svh"

package loaderPkg;

    // Address width, and count width that can still hold the full depth.
    localparam int ADDR_W  = $clog2(`LOADER_MEM_DEPTH);
    localparam int COUNT_W = $clog2(`LOADER_MEM_DEPTH + 1);

    // Word address into the instruction memory.
    typedef logic [ADDR_W-1:0] memAddr_t;

    // Number of stored words, 0 up to the full depth.
    typedef logic [COUNT_W-1:0] wordCount_t;

    // One instruction word.
    // The loader fills it byte by byte, the memory stores it whole.
    typedef union packed {
        logic [31:0]     instr;
        logic [3:0][7:0] bytes;
    } loadWord_t;

endpackage

`default_nettype wire

/* uartRx/uartRx.sv */
// 8N1 UART receiver, no parity and a fixed bit time of LOADER_CLKS_PER_BIT clocks.
// A start bit that reads high at mid-bit counts as a glitch and is dropped.
`default_nettype none

`include "loader_macros.svh"

module uartRx (
    input  wire        clk,
    input  wire        reset,
    input  wire        rx,
    output logic       byteValid,
    output logic [7:0] byteData,
    output logic       frameError
);

    localparam int CLKS_PER_BIT = `LOADER_CLKS_PER_BIT;
    localparam int TIMER_W      = $clog2(CLKS_PER_BIT);

    // Last count of a full bit, and of half a bit for the start check.
    localparam logic [TIMER_W-1:0] LAST_TICK = TIMER_W'(CLKS_PER_BIT - 1);
    localparam logic [TIMER_W-1:0] HALF_TICK = TIMER_W'(CLKS_PER_BIT / 2 - 1);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rxState_t;

    rxState_t           state;
    logic               rxMeta;
    logic               rxSync;
    logic [TIMER_W-1:0] bitTimer;
    logic [2:0]         bitIndex;
    logic [7:0]         shiftReg;
    logic               bitDone;

    // ####################
    // Input synchronizer
    // ####################

    // Both stages come out of reset at the idle level.
    always_ff @(posedge clk) begin
        if (reset) begin
            rxMeta <= 1'b1;
            rxSync <= 1'b1;
        end else begin
            rxMeta <= rx;
            rxSync <= rxMeta;
        end
    end

    // ####################
    // Receive FSM
    // ####################

    assign bitDone = (bitTimer == LAST_TICK);

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= RX_IDLE;
            bitTimer   <= '0;
            bitIndex   <= '0;
            byteValid  <= 1'b0;
            frameError <= 1'b0;
        end else begin
            byteValid  <= 1'b0;
            frameError <= 1'b0;
            case (state)
                RX_IDLE: begin
                    bitTimer <= '0;
                    if (!rxSync) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    if (bitTimer == HALF_TICK) begin
                        bitTimer <= '0;
                        bitIndex <= '0;
                        if (rxSync) begin
                            state <= RX_IDLE;
                        end else begin
                            state <= RX_DATA;
                        end
                    end else begin
                        bitTimer <= bitTimer + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (bitDone) begin
                        bitTimer <= '0;
                        bitIndex <= bitIndex + 3'd1;
                        if (bitIndex == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end else begin
                        bitTimer <= bitTimer + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (bitDone) begin
                        // Back to idle at mid stop bit, ready for the next start edge.
                        bitTimer   <= '0;
                        state      <= RX_IDLE;
                        byteValid  <= rxSync;
                        frameError <= !rxSync;
                    end else begin
                        bitTimer <= bitTimer + 1'b1;
                    end
                end
                default: begin
                    state <= RX_IDLE;
                end
            endcase
        end
    end

    // LSB arrives first, so shift in from the top.
    always_ff @(posedge clk) begin
        if (state == RX_DATA && bitDone) begin
            shiftReg <= {rxSync, shiftReg[7:1]};
        end
    end

    // Stable from the last data bit until the next start bit.
    assign byteData = shiftReg;

endmodule

`default_nettype wire

/* hdl/wordAssembler.sv */
// Packs received bytes LSB first into words and writes them in order.
// An all ones word starts the CPU and locks out all further input until reset.
`default_nettype none

`include "loader_macros.svh"

module wordAssembler
    import loaderPkg::*;
(
    input  wire        clk,
    input  wire        reset,
    input  wire        byteValid,
    input  wire  [7:0] byteData,
    input  wire        frameError,
    output logic       memWrite,
    output memAddr_t   memAddr,
    output loadWord_t  memData,
    output logic       cpuEnable,
    output wordCount_t loadedWords,
    output logic       loadError
);

    localparam wordCount_t MEM_DEPTH = wordCount_t'(`LOADER_MEM_DEPTH);

    logic [1:0] bytePos;
    loadWord_t  wordBuf;
    loadWord_t  nextWord;
    logic       lastByte;
    logic       startWord;
    logic       memFull;

    // ####################
    // Byte lanes
    // ####################

    // Word as it stands once the current byte is in its lane.
    always_comb begin
        nextWord                = wordBuf;
        nextWord.bytes[bytePos] = byteData;
    end

    assign lastByte  = (bytePos == 2'd3);
    assign startWord = (nextWord.instr == '1);
    assign memFull   = (loadedWords == MEM_DEPTH);

    always_ff @(posedge clk) begin
        if (byteValid && !cpuEnable) begin
            wordBuf <= nextWord;
        end
    end

    // ####################
    // Control and status
    // ####################

    always_ff @(posedge clk) begin
        if (reset) begin
            bytePos     <= '0;
            memWrite    <= 1'b0;
            cpuEnable   <= 1'b0;
            loadedWords <= '0;
            loadError   <= 1'b0;
        end else begin
            memWrite <= 1'b0;
            if (!cpuEnable) begin
                if (frameError) begin
                    // Drop the partial word, start over at lane 0.
                    bytePos   <= '0;
                    loadError <= 1'b1;
                end else if (byteValid) begin
                    bytePos <= bytePos + 2'd1;
                    if (lastByte) begin
                        if (startWord) begin
                            cpuEnable <= 1'b1;
                        end else if (!memFull) begin
                            memWrite    <= 1'b1;
                            loadedWords <= loadedWords + 1'b1;
                        end
                    end
                end
            end
        end
    end

    // Address is the count before this word, so words land in order.
    always_ff @(posedge clk) begin
        if (byteValid && lastByte) begin
            memAddr <= memAddr_t'(loadedWords);
            memData <= nextWord;
        end
    end

endmodule

`default_nettype wire

/* hdl/instrMem.sv */
// Instruction memory of LOADER_MEM_DEPTH words, one write port and one registered fetch port.
// Contents start as NOP words and are not cleared by reset.
`default_nettype none

`include "loader_macros.svh"

module instrMem
    import loaderPkg::*;
(
    input  wire         clk,
    input  wire         memWrite,
    input  wire  memAddr_t  memAddr,
    input  wire  loadWord_t memData,
    input  wire  memAddr_t  fetchAddr,
    output logic [31:0] fetchData
);

    logic [31:0] mem [`LOADER_MEM_DEPTH];

    // Unloaded locations execute as NOPs.
    initial begin
        for (int i = 0; i < `LOADER_MEM_DEPTH; i++) begin
            mem[i] = `LOADER_NOP_WORD;
        end
    end

    always @(posedge clk) begin
        if (memWrite) begin
            mem[memAddr] <= memData.instr;
        end
    end

    // Read during write to the same word returns the old word.
    always_ff @(posedge clk) begin
        fetchData <= mem[fetchAddr];
    end

endmodule

`default_nettype wire

/* hdl/programLoader.sv */
// Serial program loader top: UART receiver, word assembler and instruction memory.
// rx is asynchronous and idles high; fetchData lags fetchAddr by one cycle.
`default_nettype none

module programLoader
    import loaderPkg::*;
(
    input  wire         clk,
    input  wire         reset,
    input  wire         rx,
    input  wire  memAddr_t fetchAddr,
    output logic [31:0] fetchData,
    output logic        cpuEnable,
    output wordCount_t  loadedWords,
    output logic        loadError
);

    // Receiver to assembler.
    logic       byteValid;
    logic [7:0] byteData;
    logic       frameError;

    // Assembler to memory.
    logic      memWrite;
    memAddr_t  memAddr;
    loadWord_t memData;

    uartRx i_uartRx (
        .clk        (clk),
        .reset      (reset),
        .rx         (rx),
        .byteValid  (byteValid),
        .byteData   (byteData),
        .frameError (frameError)
    );

    wordAssembler i_wordAssembler (
        .clk         (clk),
        .reset       (reset),
        .byteValid   (byteValid),
        .byteData    (byteData),
        .frameError  (frameError),
        .memWrite    (memWrite),
        .memAddr     (memAddr),
        .memData     (memData),
        .cpuEnable   (cpuEnable),
        .loadedWords (loadedWords),
        .loadError   (loadError)
    );

    instrMem i_instrMem (
        .clk       (clk),
        .memWrite  (memWrite),
        .memAddr   (memAddr),
        .memData   (memData),
        .fetchAddr (fetchAddr),
        .fetchData (fetchData)
    );

endmodule

`default_nettype wire

/* verification/tbProgramLoader.sv */
// Directed testbench for programLoader. Drives 8N1 serial bytes on rx and reads back via fetch.
// Bit time follows LOADER_CLKS_PER_BIT from the shared macros.
`default_nettype none

`include "loader_macros.svh"

module tbProgramLoader
    import loaderPkg::*;
;

    localparam int        BIT_CLKS   = `LOADER_CLKS_PER_BIT;
    localparam int        WAIT_LIMIT = 4 * BIT_CLKS;
    localparam int        DEPTH      = `LOADER_MEM_DEPTH;
    localparam loadWord_t NOP_WORD   = `LOADER_NOP_WORD;
    localparam loadWord_t START_WORD = 32'hFFFF_FFFF;

    logic        clk = 1'b0;
    logic        reset;
    logic        rx;
    memAddr_t    fetchAddr;
    logic [31:0] fetchData;
    logic        cpuEnable;
    wordCount_t  loadedWords;
    logic        loadError;

    int          valueErrors   = 0;
    int          timeoutErrors = 0;
    logic [15:0] lfsrState     = 16'd64;
    loadWord_t   loaded [$];

    programLoader i_dut (
        .clk         (clk),
        .reset       (reset),
        .rx          (rx),
        .fetchAddr   (fetchAddr),
        .fetchData   (fetchData),
        .cpuEnable   (cpuEnable),
        .loadedWords (loadedWords),
        .loadError   (loadError)
    );

    always #20 clk = ~clk;

    // ####################
    // Stimulus
    // ####################

    // Taps 16, 14, 13, 11.
    function automatic logic [15:0] lfsrStep(input logic [15:0] state);
        logic feedback;
        feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], feedback};
    endfunction

    // One LFSR step per bit; the start word is never produced as data.
    function automatic loadWord_t randomWord();
        loadWord_t word;
        word.instr = '0;
        for (int i = 0; i < 32; i++) begin
            lfsrState  = lfsrStep(lfsrState);
            word.instr = {word.instr[30:0], lfsrState[0]};
        end
        if (word.instr == '1) begin
            word.instr = '0;
        end
        return word;
    endfunction

    task automatic applyReset();
        @(posedge clk);
        reset <= 1'b1;
        rx    <= 1'b1;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
    endtask

    task automatic driveBit(input logic value);
        rx <= value;
        repeat (BIT_CLKS) @(posedge clk);
    endtask

    task automatic idleBits(input int bits);
        repeat (bits * BIT_CLKS) @(posedge clk);
    endtask

    task automatic sendByte(input logic [7:0] data, input logic lowStop);
        @(posedge clk);
        driveBit(1'b0);
        for (int i = 0; i < 8; i++) begin
            driveBit(data[i]);
        end
        driveBit(!lowStop);
        // Line back to idle long enough to reject the false start.
        if (lowStop) begin
            driveBit(1'b1);
            driveBit(1'b1);
        end
    endtask

    task automatic sendWord(input loadWord_t word);
        for (int b = 0; b < 4; b++) begin
            sendByte(word.bytes[b], 1'b0);
        end
    endtask

    // ####################
    // Waits and checks
    // ####################

    task automatic waitCount(input wordCount_t target);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (loadedWords != target && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (loadedWords != target) begin
            $display("Timed out waiting for loadedWords to reach %0d", target);
            timeoutErrors++;
        end
    endtask

    task automatic waitCpuEnable();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!cpuEnable && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!cpuEnable) begin
            $display("Timed out waiting for cpuEnable to rise");
            timeoutErrors++;
        end
    endtask

    task automatic waitLoadError();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!loadError && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!loadError) begin
            $display("Timed out waiting for loadError to rise");
            timeoutErrors++;
        end
    endtask

    // Fetch data lags the address by one clock.
    task automatic checkWord(input string name, input memAddr_t addr, input loadWord_t expected);
        loadWord_t actual;
        @(posedge clk);
        fetchAddr <= addr;
        @(posedge clk);
        @(negedge clk);
        actual.instr = fetchData;
        if (actual !== expected) begin
            $display("FAIL %s: address %0d expected %h actual %h",
                     name, addr, expected.instr, actual.instr);
            valueErrors++;
        end
    endtask

    task automatic checkCount(input string name, input wordCount_t expected,
                              input wordCount_t actual);
        if (actual !== expected) begin
            $display("FAIL %s: loadedWords expected %0d actual %0d", name, expected, actual);
            valueErrors++;
        end
    endtask

    task automatic checkFlag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("FAIL %s: flag expected %b actual %b", name, expected, actual);
            valueErrors++;
        end
    endtask

    // ####################
    // Tests
    // ####################

    task automatic testPowerUp();
        checkWord("powerUp", 8'd0, NOP_WORD);
        checkWord("powerUp", 8'd100, NOP_WORD);
        checkWord("powerUp", 8'd255, NOP_WORD);
        @(negedge clk);
        checkFlag("powerUp cpuEnable", 1'b0, cpuEnable);
        checkFlag("powerUp loadError", 1'b0, loadError);
        checkCount("powerUp", '0, loadedWords);
    endtask

    task automatic testLoadOrder();
        loadWord_t word;
        for (int i = 0; i < 8; i++) begin
            word = randomWord();
            loaded.push_back(word);
            sendWord(word);
        end
        waitCount(wordCount_t'(8));
        checkCount("loadOrder", wordCount_t'(8), loadedWords);
        for (int i = 0; i < 8; i++) begin
            checkWord("loadOrder", memAddr_t'(i), loaded[i]);
        end
    endtask

    task automatic testFrameError();
        loadWord_t good;
        good = randomWord();
        sendByte(8'hA5, 1'b0);
        sendByte(8'h3C, 1'b0);
        sendByte(8'h99, 1'b1);
        waitLoadError();
        @(negedge clk);
        checkFlag("frameError loadError", 1'b1, loadError);
        checkCount("frameError partial", wordCount_t'(8), loadedWords);
        sendWord(good);
        loaded.push_back(good);
        waitCount(wordCount_t'(9));
        idleBits(2);
        @(negedge clk);
        checkCount("frameError", wordCount_t'(9), loadedWords);
        checkWord("frameError", 8'd8, good);
    endtask

    task automatic testStartWord();
        sendWord(START_WORD);
        waitCpuEnable();
        @(negedge clk);
        checkFlag("startWord cpuEnable", 1'b1, cpuEnable);
        checkCount("startWord", wordCount_t'(9), loadedWords);
        // Nothing observable changes under lockout.
        sendWord(randomWord());
        idleBits(4);
        @(negedge clk);
        checkCount("startWord lockout", wordCount_t'(9), loadedWords);
        checkWord("startWord lockout", 8'd9, NOP_WORD);
    endtask

    task automatic testFullMemory();
        loadWord_t fullWords [DEPTH + 1];
        applyReset();
        @(negedge clk);
        checkFlag("fullMemory cpuEnable", 1'b0, cpuEnable);
        checkFlag("fullMemory loadError", 1'b0, loadError);
        checkCount("fullMemory reset", '0, loadedWords);
        for (int i = 0; i <= DEPTH; i++) begin
            fullWords[i] = randomWord();
            sendWord(fullWords[i]);
        end
        waitCount(wordCount_t'(DEPTH));
        idleBits(2);
        @(negedge clk);
        checkCount("fullMemory", wordCount_t'(DEPTH), loadedWords);
        // Word 257 must not land anywhere.
        for (int i = 0; i < DEPTH; i++) begin
            checkWord("fullMemory", memAddr_t'(i), fullWords[i]);
        end
    endtask

    initial begin
        reset     <= 1'b1;
        rx        <= 1'b1;
        fetchAddr <= '0;
        applyReset();
        testPowerUp();
        testLoadOrder();
        testFrameError();
        testStartWord();
        testFullMemory();
        $display("Errors: %0d value, %0d timeout", valueErrors, timeoutErrors);
        if (valueErrors == 0 && timeoutErrors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
+incdir+common
common/loaderPkg.sv
uartRx/uartRx.sv
hdl/wordAssembler.sv
hdl/instrMem.sv
hdl/programLoader.sv
verification/tbProgramLoader.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the program loader testbench with Verilator and runs it.
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary -j 0 \
    --top-module tbProgramLoader \
    -f src.f \
    -o simProgramLoader

./obj_dir/simProgramLoader | tee sim.log

if grep -q "Test failed" sim.log; then
    echo "Simulation reported errors, see sim.log"
    exit 1
fi

echo "Simulation finished without errors"
exit 0
